//--- hdl/rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [3:0]      alu_op_t;
	typedef logic [1:0]      wb_sel_t;

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_AND    = 4'd2;
	localparam alu_op_t ALU_OR     = 4'd3;
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_SLT    = 4'd5;
	localparam alu_op_t ALU_SLTU   = 4'd6;
	localparam alu_op_t ALU_SLL    = 4'd7;
	localparam alu_op_t ALU_SRL    = 4'd8;
	localparam alu_op_t ALU_SRA    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10; // LUI

	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_LUI    = 7'b0110111;

	localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0
	localparam word_t RESET_PC  = '0;

	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;
	localparam wb_sel_t WB_PC4 = 2'd2;

	// Operand source in execute
	localparam logic [1:0] FWD_NONE = 2'd0;
	localparam logic [1:0] FWD_MEM  = 2'd1;
	localparam logic [1:0] FWD_WB   = 2'd2;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src;   // Immediate as second operand
		logic    branch;
		logic    branch_ne; // BNE rather than BEQ
		logic    jump;
		logic    jalr;
		wb_sel_t wb_sel;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  we;
		logic  re;
	} dm_req_t;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic          clk,
	input  logic          rst,
	input  logic          stall,
	input  logic          redirect,
	input  rv_pkg::word_t redirect_pc,
	output rv_pkg::word_t imem_addr,
	input  rv_pkg::word_t imem_rdata,
	output rv_pkg::word_t if_id_instr,
	output rv_pkg::word_t if_id_pc
);
	import rv_pkg::*;

	word_t pc;
	word_t pc_next;

	// Redirect takes priority over a load-use hold
	always_comb begin
		if (redirect)
			pc_next = redirect_pc;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	assign imem_addr = pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			if_id_instr <= NOP_INSTR;
			if_id_pc    <= RESET_PC;
		end else if (redirect) begin
			if_id_instr <= NOP_INSTR; // Wrong-path fetch
			if_id_pc    <= pc;
		end else if (!stall) begin
			if_id_instr <= imem_rdata;
			if_id_pc    <= pc;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		redirect |=> pc == $past(redirect_pc))
		else $error("PC did not follow the redirect target");

endmodule

//--- hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  rv_pkg::word_t instr,
	output rv_pkg::ctrl_t ctrl,
	output rv_pkg::word_t imm
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	// alt is funct7 bit 5, only meaningful for SUB and the right shifts
	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		imm  = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_sel(funct3, instr[30], 1'b1);
			end
			OP_ITYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = alu_sel(funct3, instr[30], 1'b0);
				imm            = {{20{instr[31]}}, instr[31:20]};
			end
			OP_LOAD: begin
				if (funct3 == 3'b010) begin // LW only
					ctrl.reg_write = 1'b1;
					ctrl.mem_read  = 1'b1;
					ctrl.alu_src   = 1'b1;
					ctrl.wb_sel    = WB_MEM;
					imm            = {{20{instr[31]}}, instr[31:20]};
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b010) begin // SW only
					ctrl.mem_write = 1'b1;
					ctrl.alu_src   = 1'b1;
					imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				end
			end
			OP_BRANCH: begin
				if (funct3[2:1] == 2'b00) begin // BEQ, BNE
					ctrl.branch    = 1'b1;
					ctrl.branch_ne = funct3[0];
					imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
						instr[11:8], 1'b0};
				end
			end
			OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
				ctrl.wb_sel    = WB_PC4;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			OP_JALR: begin
				ctrl.reg_write = 1'b1;
				ctrl.jalr      = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.wb_sel    = WB_PC4;
				imm            = {{20{instr[31]}}, instr[31:20]};
			end
			OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = ALU_PASS_B;
				imm            = {instr[31:12], 12'b0};
			end
			default: ; // Unknown opcode behaves as a bubble
		endcase
	end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	input  rv_pkg::reg_addr_t rd,
	input  logic              we,
	input  rv_pkg::word_t     wdata,
	output rv_pkg::word_t     rdata1,
	output rv_pkg::word_t     rdata2
);
	import rv_pkg::*;

	word_t regs [1:31]; // x0 is not stored

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Same-cycle write is visible to decode
	assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- hdl/hazard_forward.sv
`timescale 1ns/1ps

module hazard_forward (
	input  rv_pkg::reg_addr_t id_rs1,
	input  rv_pkg::reg_addr_t id_rs2,
	input  rv_pkg::reg_addr_t ex_rs1,
	input  rv_pkg::reg_addr_t ex_rs2,
	input  rv_pkg::reg_addr_t ex_rd,
	input  rv_pkg::reg_addr_t mem_rd,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic              ex_mem_read,
	input  logic              mem_reg_write,
	input  logic              wb_reg_write,
	output logic              stall,
	output logic [1:0]        fwd_a,
	output logic [1:0]        fwd_b
);
	import rv_pkg::*;

	// Youngest producer wins
	function automatic logic [1:0] fwd_sel(input reg_addr_t rs, input reg_addr_t m_rd,
			input logic m_we, input reg_addr_t w_rd, input logic w_we);
		if (rs == '0)
			return FWD_NONE;
		else if (m_we && m_rd == rs)
			return FWD_MEM;
		else if (w_we && w_rd == rs)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	// Load data is not ready until writeback
	assign stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	assign fwd_a = fwd_sel(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = fwd_sel(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  rv_pkg::ctrl_t ctrl,
	input  rv_pkg::word_t pc,
	input  rv_pkg::word_t imm,
	input  rv_pkg::word_t rdata1,
	input  rv_pkg::word_t rdata2,
	input  rv_pkg::word_t mem_fwd,
	input  rv_pkg::word_t wb_fwd,
	input  logic [1:0]    fwd_a,
	input  logic [1:0]    fwd_b,
	output rv_pkg::word_t alu_result,
	output rv_pkg::word_t store_data,
	output logic          redirect,
	output rv_pkg::word_t redirect_pc
);
	import rv_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t src_b;
	logic  equal;
	logic  taken;

	function automatic word_t fwd_mux(input logic [1:0] sel, input word_t reg_val,
			input word_t mem_val, input word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a       = fwd_mux(fwd_a, rdata1, mem_fwd, wb_fwd);
	assign op_b       = fwd_mux(fwd_b, rdata2, mem_fwd, wb_fwd);
	assign src_b      = ctrl.alu_src ? imm : op_b;
	assign store_data = op_b; // SW data after forwarding

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:    alu_result = op_a + src_b;
			ALU_SUB:    alu_result = op_a - src_b;
			ALU_AND:    alu_result = op_a & src_b;
			ALU_OR:     alu_result = op_a | src_b;
			ALU_XOR:    alu_result = op_a ^ src_b;
			ALU_SLT:    alu_result = word_t'($signed(op_a) < $signed(src_b));
			ALU_SLTU:   alu_result = word_t'(op_a < src_b);
			ALU_SLL:    alu_result = op_a << src_b[4:0];
			ALU_SRL:    alu_result = op_a >> src_b[4:0];
			ALU_SRA:    alu_result = word_t'($signed(op_a) >>> src_b[4:0]);
			ALU_PASS_B: alu_result = src_b;
			default:    alu_result = op_a + src_b;
		endcase
	end

	assign equal = (op_a == op_b);
	assign taken = ctrl.branch && (equal != ctrl.branch_ne);

	assign redirect = ctrl.jump || ctrl.jalr || taken;

	// JALR target is rs1+imm with bit 0 cleared
	assign redirect_pc = ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : pc + imm;

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic            clk,
	input  logic            rst,
	output rv_pkg::word_t   imem_addr,
	input  rv_pkg::word_t   imem_rdata,
	output rv_pkg::dm_req_t dm_req,
	input  rv_pkg::word_t   dm_rdata
);
	import rv_pkg::*;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc;
		word_t     imm;
		word_t     rdata1;
		word_t     rdata2;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     alu;
		word_t     pc4;
		word_t     store_data;
		reg_addr_t rd;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		wb_sel_t   wb_sel;
		reg_addr_t rd;
		word_t     result;
		word_t     load_data;
	} mem_wb_t;

	word_t      if_id_instr;
	word_t      if_id_pc;
	ctrl_t      id_ctrl;
	word_t      id_imm;
	word_t      id_rdata1;
	word_t      id_rdata2;
	logic       stall;
	logic       redirect;
	word_t      redirect_pc;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	word_t      ex_alu;
	word_t      ex_store;
	word_t      mem_result;
	word_t      wb_data;
	id_ex_t     id_ex;
	ex_mem_t    ex_mem;
	mem_wb_t    mem_wb;

	fetch_stage fetch_stage_inst (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.imem_addr   (imem_addr),
		.imem_rdata  (imem_rdata),
		.if_id_instr (if_id_instr),
		.if_id_pc    (if_id_pc)
	);

	decode_unit decode_unit_inst (.instr(if_id_instr), .ctrl(id_ctrl), .imm(id_imm));

	reg_file reg_file_inst (
		.clk    (clk),
		.rst    (rst),
		.rs1    (if_id_instr[19:15]),
		.rs2    (if_id_instr[24:20]),
		.rd     (mem_wb.rd),
		.we     (mem_wb.reg_write),
		.wdata  (wb_data),
		.rdata1 (id_rdata1),
		.rdata2 (id_rdata2)
	);

	hazard_forward hazard_forward_inst (
		.id_rs1        (if_id_instr[19:15]),
		.id_rs2        (if_id_instr[24:20]),
		.ex_rs1        (id_ex.rs1),
		.ex_rs2        (id_ex.rs2),
		.ex_rd         (id_ex.rd),
		.mem_rd        (ex_mem.rd),
		.wb_rd         (mem_wb.rd),
		.ex_mem_read   (id_ex.ctrl.mem_read),
		.mem_reg_write (ex_mem.ctrl.reg_write),
		.wb_reg_write  (mem_wb.reg_write),
		.stall         (stall),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b)
	);

	// Bubble on a load-use stall or a taken redirect
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			id_ex <= '0;
		else if (redirect || stall)
			id_ex <= '0;
		else
			id_ex <= '{ctrl: id_ctrl, pc: if_id_pc, imm: id_imm, rdata1: id_rdata1,
				rdata2: id_rdata2, rs1: if_id_instr[19:15], rs2: if_id_instr[24:20],
				rd: if_id_instr[11:7]};
	end

	execute_stage execute_stage_inst (
		.ctrl        (id_ex.ctrl),
		.pc          (id_ex.pc),
		.imm         (id_ex.imm),
		.rdata1      (id_ex.rdata1),
		.rdata2      (id_ex.rdata2),
		.mem_fwd     (mem_result),
		.wb_fwd      (wb_data),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.alu_result  (ex_alu),
		.store_data  (ex_store),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ex_mem <= '0;
		else
			ex_mem <= '{ctrl: id_ex.ctrl, alu: ex_alu, pc4: id_ex.pc + 32'd4,
				store_data: ex_store, rd: id_ex.rd};
	end

	assign dm_req = '{addr: ex_mem.alu, wdata: ex_mem.store_data,
		we: ex_mem.ctrl.mem_write, re: ex_mem.ctrl.mem_read};

	assign mem_result = (ex_mem.ctrl.wb_sel == WB_PC4) ? ex_mem.pc4 : ex_mem.alu; // Link value

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			mem_wb <= '0;
		else
			mem_wb <= '{reg_write: ex_mem.ctrl.reg_write, wb_sel: ex_mem.ctrl.wb_sel,
				rd: ex_mem.rd, result: mem_result, load_data: dm_rdata};
	end

	always_comb begin
		case (mem_wb.wb_sel)
			WB_MEM:  wb_data = mem_wb.load_data;
			default: wb_data = mem_wb.result; // ALU or PC+4
		endcase
	end

	assert property (@(posedge clk) disable iff (rst) !(dm_req.we && dm_req.re))
		else $error("Data memory read and write in the same cycle");

endmodule

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
	rv_pkg::word_t addr;
	rv_pkg::word_t data;
} exp_write_t;

function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
	return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP_RTYPE};
endfunction

function automatic rv_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic rv_pkg::word_t enc_sw(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::OP_STORE};
endfunction

function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
		input int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic rv_pkg::word_t enc_jal(input int rd, input int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OP_JAL};
endfunction

localparam int PROG_LEN = 51;

localparam rv_pkg::word_t PROG [PROG_LEN] = '{
	enc_i(rv_pkg::OP_ITYPE, 3'b000, 1, 0, 7), enc_i(rv_pkg::OP_ITYPE, 3'b000, 2, 0, -3),
	enc_r(7'h00, 3'b000, 3, 1, 2), enc_sw(3, 0, 0),    // add
	enc_r(7'h20, 3'b000, 4, 1, 2), enc_sw(4, 0, 4),    // sub
	enc_r(7'h00, 3'b111, 5, 1, 2), enc_sw(5, 0, 8),
	enc_r(7'h00, 3'b110, 6, 1, 2), enc_sw(6, 0, 12),
	enc_r(7'h00, 3'b100, 7, 1, 2), enc_sw(7, 0, 16),
	enc_r(7'h00, 3'b010, 8, 2, 1), enc_r(7'h00, 3'b011, 9, 2, 1),
	enc_sw(8, 0, 20), enc_sw(9, 0, 24),
	enc_r(7'h00, 3'b001, 10, 1, 1), enc_i(rv_pkg::OP_ITYPE, 3'b101, 11, 2, 'h401), // srai 1
	enc_r(7'h00, 3'b101, 12, 2, 1), {20'h12345, 5'd13, rv_pkg::OP_LUI},
	enc_sw(10, 0, 28), enc_sw(11, 0, 32), enc_sw(12, 0, 36), enc_sw(13, 0, 40),
	// Dependency chain at distances one to three
	enc_i(rv_pkg::OP_ITYPE, 3'b000, 14, 0, 1), enc_i(rv_pkg::OP_ITYPE, 3'b000, 15, 14, 2),
	enc_i(rv_pkg::OP_ITYPE, 3'b000, 16, 14, 4), enc_r(7'h00, 3'b000, 17, 14, 15),
	enc_r(7'h00, 3'b000, 18, 17, 16), enc_sw(18, 0, 44),
	enc_i(rv_pkg::OP_LOAD, 3'b010, 19, 0, 0), enc_i(rv_pkg::OP_ITYPE, 3'b000, 20, 19, 100),
	enc_sw(20, 0, 48),
	enc_b(3'b000, 1, 1, 8), enc_sw(1, 0, 52),          // taken, store skipped
	enc_b(3'b001, 1, 2, 8), enc_sw(2, 0, 52),          // taken, store skipped
	enc_b(3'b000, 1, 2, 8), enc_sw(1, 0, 52),
	enc_b(3'b001, 1, 1, 8), enc_sw(2, 0, 56),
	enc_jal(21, 12), enc_sw(1, 0, 60), enc_sw(1, 0, 60), enc_sw(21, 0, 60),
	enc_i(rv_pkg::OP_ITYPE, 3'b000, 22, 0, 192), enc_i(rv_pkg::OP_JALR, 3'b000, 23, 22, 4),
	enc_sw(1, 0, 64), enc_sw(1, 0, 64), enc_sw(23, 0, 64),
	enc_jal(0, 0)                                      // Park here
};

localparam int EXP_LEN = 17;

localparam exp_write_t EXP_WRITES [EXP_LEN] = '{
	'{32'd0, 32'd4}, '{32'd4, 32'd10}, '{32'd8, 32'd5}, '{32'd12, 32'hFFFF_FFFF},
	'{32'd16, 32'hFFFF_FFFA}, '{32'd20, 32'd1}, '{32'd24, 32'd0}, '{32'd28, 32'h0000_0380},
	'{32'd32, 32'hFFFF_FFFE}, '{32'd36, 32'h01FF_FFFF}, '{32'd40, 32'h1234_5000},
	'{32'd44, 32'd9}, '{32'd48, 32'd104}, '{32'd52, 32'd7}, '{32'd56, 32'hFFFF_FFFD},
	'{32'd60, 32'd168}, '{32'd64, 32'd188}
};

localparam string EXP_NAMES [EXP_LEN] = '{
	"add", "sub", "and", "or", "xor", "slt", "sltu", "sll", "srai", "srl", "lui",
	"fwd_chain", "load_use", "beq_not_taken", "bne_not_taken", "jal_link", "jalr_link"
};

`endif

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
	import rv_pkg::*;

	`include "tb_program.svh"

	// About 80 cycles with stalls and flushes, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 400;
	localparam int DRAIN_CYCLES   = 10; // Catch stray writes after the last store

	logic    clk;
	logic    rst;
	word_t   imem_addr;
	word_t   imem_rdata;
	dm_req_t dm_req;
	word_t   dm_rdata;

	word_t dram [256];
	int    exp_idx;
	int    cycle_count;
	int    error_count;

	rv_core rv_core_inst (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dm_req     (dm_req),
		.dm_rdata   (dm_rdata)
	);

	always #2 clk = ~clk;

	function automatic word_t rom_read(input word_t addr);
		int idx;
		idx = int'(addr[31:2]);
		if (addr[31:2] < PROG_LEN)
			return PROG[idx];
		return NOP_INSTR; // Past the end of the image
	endfunction

	assign imem_rdata = rom_read(imem_addr);
	assign dm_rdata   = dm_req.re ? dram[dm_req.addr[9:2]] : '0; // Driven only on a read

	always @(posedge clk) begin
		if (dm_req.we)
			dram[dm_req.addr[9:2]] <= dm_req.wdata;
	end

	always @(posedge clk or posedge rst) begin
		if (rst)
			exp_idx <= 0;
		else if (dm_req.we && exp_idx < EXP_LEN)
			exp_idx <= exp_idx + 1;
	end

	always @(posedge clk or posedge rst) begin
		if (rst)
			cycle_count <= 0;
		else
			cycle_count <= cycle_count + 1;
	end

	assert property (@(posedge clk) disable iff (rst)
		(dm_req.we && exp_idx < EXP_LEN) |-> dm_req.addr == EXP_WRITES[exp_idx].addr)
		else begin
			$display("[FAIL] %s address: expected %h, actual %h",
				EXP_NAMES[$sampled(exp_idx)], EXP_WRITES[$sampled(exp_idx)].addr,
				$sampled(dm_req.addr));
			error_count++;
		end

	assert property (@(posedge clk) disable iff (rst)
		(dm_req.we && exp_idx < EXP_LEN) |-> dm_req.wdata == EXP_WRITES[exp_idx].data)
		else begin
			$display("[FAIL] %s data: expected %h, actual %h",
				EXP_NAMES[$sampled(exp_idx)], EXP_WRITES[$sampled(exp_idx)].data,
				$sampled(dm_req.wdata));
			error_count++;
		end

	assert property (@(posedge clk) disable iff (rst) dm_req.we |-> exp_idx < EXP_LEN)
		else begin
			$display("Unexpected extra data-memory write to address %h",
				$sampled(dm_req.addr));
			error_count++;
		end

	// Nothing touches data memory during reset
	assert property (@(posedge clk) rst |-> !dm_req.we && !dm_req.re)
		else begin
			$display("Data memory was accessed while reset was asserted");
			error_count++;
		end

	// First access must be the first store, the load comes later
	assert property (@(posedge clk) disable iff (rst) exp_idx == 0 |-> !dm_req.re)
		else begin
			$display("Data memory was read before the first store reached memory");
			error_count++;
		end

	initial begin
		for (int i = 0; i < 256; i++)
			dram[i] = 32'hA5A5_0000 ^ (i * 32'h0001_0104);
		clk         = 1'b0;
		rst         = 1'b1;
		error_count = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		while (exp_idx < EXP_LEN && cycle_count < TIMEOUT_CYCLES)
			@(posedge clk);

		if (exp_idx < EXP_LEN) begin
			$display("Timeout after %0d cycles with %0d of %0d expected writes seen",
				cycle_count, exp_idx, EXP_LEN);
			error_count++;
		end else begin
			repeat (DRAIN_CYCLES) @(posedge clk);
		end

		$display("Done: %0d of %0d writes seen, %0d cycles, %0d errors",
			exp_idx, EXP_LEN, cycle_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- all.f
+incdir+include
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_forward.sv
hdl/execute_stage.sv
hdl/rv_core.sv
sim/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - target: any(rtl, test)
    files:
      - hdl/rv_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_unit.sv
      - hdl/reg_file.sv
      - hdl/hazard_forward.sv
      - hdl/execute_stage.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_rv_core.sv
